//--- hw/fpu_pkg.sv
package fpu_pkg;

	typedef logic [31:0] word_t;

	typedef enum logic [4:0]
	{
		FPU_OP_NOP     = 5'd0,
		FPU_OP_MOV     = 5'd1,
		FPU_OP_MTC     = 5'd2,
		FPU_OP_MFC     = 5'd3,
		FPU_OP_NEG     = 5'd4,
		FPU_OP_ABS     = 5'd5,
		FPU_OP_COND    = 5'd6,
		FPU_OP_CEIL    = 5'd7,
		FPU_OP_FLOOR   = 5'd8,
		FPU_OP_TRUNC   = 5'd9,
		FPU_OP_ROUND   = 5'd10,
		FPU_OP_CVTW    = 5'd11,
		FPU_OP_CTC     = 5'd12,
		FPU_OP_CFC     = 5'd13,
		FPU_OP_INVALID = 5'd14
	} fpu_op_t;

	typedef struct packed
	{
		fpu_op_t     op;
		logic [3:0]  cond;    // [2:0] relation, [3] signalling form
		logic [2:0]  cc;
		logic [4:0]  ctl_sel;
		word_t       gpr;
		word_t       fs;
		word_t       ft;
	} fpu_req_t;

	// low five bits line up with the FCSR flag field
	typedef struct packed
	{
		logic unimpl;
		logic invalid;
		logic divided_by_zero;
		logic overflow;
		logic underflow;
		logic inexact;
	} fpu_except_t;

	typedef struct packed
	{
		logic [7:0] fcc;
		logic       fs;
		logic [5:0] cause;
		logic [4:0] enables;
		logic [4:0] flags;
		logic [1:0] rm;
	} fcsr_t;

	typedef struct packed
	{
		logic [6:0] fcc_hi;
		logic       fs;
		logic       fcc0;
		logic [4:0] zero;
		logic [5:0] cause;
		logic [4:0] enables;
		logic [4:0] flags;
		logic [1:0] rm;
	} fcsr31_t;

	typedef union packed
	{
		word_t   raw;
		fcsr31_t f31;
	} fcsr_word_u;

	typedef struct packed
	{
		word_t       fpu_ret;
		word_t       cpu_ret;
		fpu_except_t except;
	} fpu_resp_t;

	typedef enum logic [1:0]
	{
		FCSR_ARITH = 2'd0,
		FCSR_FCC   = 2'd1,
		FCSR_CTC   = 2'd2
	} fcsr_kind_t;

	localparam logic [1:0] RM_NEAREST = 2'd0;
	localparam logic [1:0] RM_ZERO    = 2'd1;
	localparam logic [1:0] RM_UP      = 2'd2;
	localparam logic [1:0] RM_DOWN    = 2'd3;

	function automatic logic is_nan(input word_t x);
		return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
	endfunction

endpackage

//--- hw/fpu_float2int.sv
`timescale 1ns/100ps

module fpu_float2int (
	input  fpu_pkg::word_t fval,
	output fpu_pkg::word_t ceil_w,
	output fpu_pkg::word_t floor_w,
	output fpu_pkg::word_t trunc_w,
	output fpu_pkg::word_t round_w,
	output logic           invalid_ceil,
	output logic           invalid_floor,
	output logic           invalid_trunc,
	output logic           invalid_round
);
	import fpu_pkg::*;

	logic        sign;
	logic [7:0]  exp_f;
	logic [23:0] man;
	logic        huge;      // nan, inf or magnitude >= 2^32
	logic [31:0] int_part;
	logic        half;
	logic        sticky;
	logic [47:0] ext;

	assign sign  = fval[31];
	assign exp_f = fval[30:23];
	assign man   = {exp_f != 8'd0, fval[22:0]};
	assign huge  = (exp_f > 8'd158);

	// split magnitude into integer part, half bit and sticky rest
	always_comb
	begin
		int_part = 32'd0;
		half     = 1'b0;
		sticky   = 1'b0;
		ext      = 48'd0;
		if (exp_f >= 8'd150)
		begin
			int_part = {8'd0, man} << (exp_f - 8'd150);
		end
		else if (exp_f >= 8'd126)
		begin
			ext      = {man, 24'd0} >> (8'd150 - exp_f);
			int_part = {8'd0, ext[47:24]};
			half     = ext[23];
			sticky   = |ext[22:0];
		end
		else
		begin
			sticky = |man;   // below one half
		end
	end

	// returns {invalid, word} for one rounding direction
	function automatic logic [32:0] to_int(input logic [1:0] mode);
		logic        inc;
		logic [32:0] mag;
		logic [31:0] res;
		logic        bad;
		case (mode)
			RM_NEAREST: inc = half & (sticky | int_part[0]);
			RM_UP:      inc = ~sign & (half | sticky);
			RM_DOWN:    inc = sign & (half | sticky);
			default:    inc = 1'b0;
		endcase
		mag = {1'b0, int_part} + {32'd0, inc};
		if (sign)
			bad = (mag > 33'h080000000);
		else
			bad = (mag > 33'h07fffffff);
		bad = bad | huge;
		res = sign ? (~mag[31:0] + 32'd1) : mag[31:0];
		if (bad)
			res = 32'h7fffffff;
		return {bad, res};
	endfunction

	assign {invalid_ceil, ceil_w}   = to_int(RM_UP);
	assign {invalid_floor, floor_w} = to_int(RM_DOWN);
	assign {invalid_trunc, trunc_w} = to_int(RM_ZERO);
	assign {invalid_round, round_w} = to_int(RM_NEAREST);

endmodule

//--- hw/fpu_compare.sv
`timescale 1ns/100ps

module fpu_compare (
	input  logic           clk,
	input  logic           rst_n,
	input  fpu_pkg::word_t fs,
	input  fpu_pkg::word_t ft,
	input  logic [3:0]     cond,
	input  logic [2:0]     cc,
	input  logic [7:0]     fcc_in,
	output logic [7:0]     fcc_out
);
	import fpu_pkg::*;

	logic       unordered;
	logic       both_zero;
	logic       equal;
	logic       less;
	logic       hit;
	logic [7:0] fcc_next;

	assign unordered = is_nan(fs) | is_nan(ft);
	assign both_zero = (fs[30:0] == 31'd0) && (ft[30:0] == 31'd0);
	assign equal     = ~unordered & ((fs == ft) | both_zero);

	always_comb
	begin
		if (unordered || both_zero)
			less = 1'b0;
		else if (fs[31] != ft[31])
			less = fs[31];
		else if (!fs[31])
			less = fs[30:0] < ft[30:0];
		else
			less = fs[30:0] > ft[30:0];   // both negative
	end

	// cond bit 3 only matters for trapping, relation is in [2:0]
	assign hit = (cond[0] & unordered) | (cond[1] & equal) | (cond[2] & less);

	always_comb
	begin
		fcc_next     = fcc_in;
		fcc_next[cc] = hit;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			fcc_out <= 8'd0;
		else
			fcc_out <= fcc_next;
	end

endmodule

//--- hw/fpu_csr.sv
`timescale 1ns/100ps

module fpu_csr (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 fcsr_we,
	input  fpu_pkg::fcsr_kind_t  fcsr_kind,
	input  fpu_pkg::fpu_except_t except,
	input  logic [7:0]           new_fcc,
	input  logic [4:0]           ctl_sel,
	input  fpu_pkg::word_t       gpr,
	output fpu_pkg::fcsr_t       fcsr,
	output fpu_pkg::word_t       ctl_rdata
);
	import fpu_pkg::*;

	fcsr_word_u wr_w;
	fcsr_word_u rd_w;

	assign wr_w.raw = gpr;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			fcsr <= '0;
		end
		else if (fcsr_we)
		begin
			case (fcsr_kind)
				FCSR_ARITH:
				begin
					fcsr.cause <= except;
					fcsr.flags <= fcsr.flags | except[4:0];   // sticky
				end
				FCSR_FCC: fcsr.fcc <= new_fcc;
				FCSR_CTC:
				begin
					case (ctl_sel)
						5'd25: fcsr.fcc <= wr_w.raw[7:0];
						5'd26:
						begin
							fcsr.cause <= wr_w.f31.cause;
							fcsr.flags <= wr_w.f31.flags;
						end
						5'd28:
						begin
							fcsr.fs      <= wr_w.raw[2];
							fcsr.rm      <= wr_w.f31.rm;
							fcsr.enables <= wr_w.f31.enables;
						end
						5'd31:
						begin
							fcsr.fcc     <= {wr_w.f31.fcc_hi, wr_w.f31.fcc0};
							fcsr.fs      <= wr_w.f31.fs;
							fcsr.cause   <= wr_w.f31.cause;
							fcsr.enables <= wr_w.f31.enables;
							fcsr.flags   <= wr_w.f31.flags;
							fcsr.rm      <= wr_w.f31.rm;
						end
						default: ;   // unknown register, no write
					endcase
				end
				default: ;
			endcase
		end
	end

	// CFC view, unused bits read zero
	always_comb
	begin
		rd_w.raw = '0;
		case (ctl_sel)
			5'd25: rd_w.raw[7:0] = fcsr.fcc;
			5'd26:
			begin
				rd_w.f31.cause = fcsr.cause;
				rd_w.f31.flags = fcsr.flags;
			end
			5'd28:
			begin
				rd_w.f31.enables = fcsr.enables;
				rd_w.raw[2]      = fcsr.fs;
				rd_w.f31.rm      = fcsr.rm;
			end
			5'd31:
			begin
				rd_w.f31.fcc_hi  = fcsr.fcc[7:1];
				rd_w.f31.fs      = fcsr.fs;
				rd_w.f31.fcc0    = fcsr.fcc[0];
				rd_w.f31.cause   = fcsr.cause;
				rd_w.f31.enables = fcsr.enables;
				rd_w.f31.flags   = fcsr.flags;
				rd_w.f31.rm      = fcsr.rm;
			end
			default: ;
		endcase
	end

	assign ctl_rdata = rd_w.raw;

	// one write per transaction
	a_single_we: assert property (@(posedge clk) disable iff (!rst_n) fcsr_we |=> !fcsr_we);

endmodule

//--- hw/fpu_ex.sv
`timescale 1ns/100ps

module fpu_ex (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 req,
	input  fpu_pkg::fpu_req_t    cmd,
	output logic                 ack,
	output fpu_pkg::fpu_resp_t   resp,
	output fpu_pkg::word_t       src_a,
	output fpu_pkg::word_t       src_b,
	output logic [3:0]           cmp_cond,
	output logic [2:0]           cmp_cc,
	input  logic [7:0]           cmp_fcc,
	input  fpu_pkg::word_t       ceil_w,
	input  fpu_pkg::word_t       floor_w,
	input  fpu_pkg::word_t       trunc_w,
	input  fpu_pkg::word_t       round_w,
	input  logic                 invalid_ceil,
	input  logic                 invalid_floor,
	input  logic                 invalid_trunc,
	input  logic                 invalid_round,
	input  fpu_pkg::fcsr_t       fcsr,
	input  fpu_pkg::word_t       ctl_rdata,
	output logic                 fcsr_we,
	output fpu_pkg::fcsr_kind_t  fcsr_kind,
	output fpu_pkg::fpu_except_t except,
	output logic [7:0]           new_fcc,
	output logic [4:0]           ctl_sel,
	output fpu_pkg::word_t       gpr
);
	import fpu_pkg::*;

	logic [1:0]  lat;
	logic [1:0]  cnt;
	logic        wr_fcsr;
	logic [1:0]  conv_mode;
	word_t       conv_w;
	logic        conv_inv;
	word_t       conv_w_q;
	logic        conv_inv_q;
	word_t       fs_q;
	logic        fs_nan;
	fpu_resp_t   resp_c;

	assign src_a    = cmd.fs;
	assign src_b    = cmd.ft;
	assign cmp_cond = cmd.cond;
	assign cmp_cc   = cmd.cc;
	assign new_fcc  = cmp_fcc;
	assign ctl_sel  = cmd.ctl_sel;
	assign gpr      = cmd.gpr;
	assign except   = resp.except;
	assign fs_nan   = is_nan(cmd.fs);

	always_comb
	begin
		lat       = 2'd1;
		wr_fcsr   = 1'b0;
		fcsr_kind = FCSR_ARITH;
		conv_mode = fcsr.rm;   // CVTW
		case (cmd.op)
			FPU_OP_COND:
			begin
				lat       = 2'd2;
				wr_fcsr   = 1'b1;
				fcsr_kind = FCSR_FCC;
			end
			FPU_OP_CTC:
			begin
				wr_fcsr   = 1'b1;
				fcsr_kind = FCSR_CTC;
			end
			FPU_OP_MFC:  lat = 2'd2;
			FPU_OP_NEG, FPU_OP_ABS: wr_fcsr = 1'b1;
			FPU_OP_CEIL, FPU_OP_FLOOR, FPU_OP_TRUNC, FPU_OP_ROUND, FPU_OP_CVTW:
			begin
				lat     = 2'd2;
				wr_fcsr = 1'b1;
			end
			default: ;
		endcase
		case (cmd.op)
			FPU_OP_CEIL:  conv_mode = RM_UP;
			FPU_OP_FLOOR: conv_mode = RM_DOWN;
			FPU_OP_TRUNC: conv_mode = RM_ZERO;
			FPU_OP_ROUND: conv_mode = RM_NEAREST;
			default: ;
		endcase
	end

	always_comb
	begin
		case (conv_mode)
			RM_NEAREST: {conv_inv, conv_w} = {invalid_round, round_w};
			RM_ZERO:    {conv_inv, conv_w} = {invalid_trunc, trunc_w};
			RM_UP:      {conv_inv, conv_w} = {invalid_ceil, ceil_w};
			default:    {conv_inv, conv_w} = {invalid_floor, floor_w};
		endcase
	end

	always_ff @(posedge clk)
	begin
		conv_w_q   <= conv_w;
		conv_inv_q <= conv_inv;
		fs_q       <= cmd.fs;
	end

	always_comb
	begin
		resp_c = '0;
		case (cmd.op)
			FPU_OP_MOV: resp_c.fpu_ret = cmd.fs;
			FPU_OP_MTC: resp_c.fpu_ret = cmd.gpr;
			FPU_OP_MFC: resp_c.cpu_ret = fs_q;
			FPU_OP_NEG:
			begin
				resp_c.fpu_ret        = fs_nan ? cmd.fs : {~cmd.fs[31], cmd.fs[30:0]};
				resp_c.except.invalid = fs_nan;
			end
			FPU_OP_ABS:
			begin
				resp_c.fpu_ret        = fs_nan ? cmd.fs : {1'b0, cmd.fs[30:0]};
				resp_c.except.invalid = fs_nan;
			end
			FPU_OP_CEIL, FPU_OP_FLOOR, FPU_OP_TRUNC, FPU_OP_ROUND, FPU_OP_CVTW:
			begin
				resp_c.fpu_ret        = conv_w_q;
				resp_c.except.invalid = conv_inv_q;
			end
			FPU_OP_CFC:     resp_c.cpu_ret = ctl_rdata;
			FPU_OP_INVALID: resp_c.except.unimpl = 1'b1;
			default: ;
		endcase
	end

	// latency countdown and four-phase ack
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cnt     <= 2'd0;
			ack     <= 1'b0;
			fcsr_we <= 1'b0;
		end
		else
		begin
			fcsr_we <= 1'b0;
			if (ack)
			begin
				if (!req)
					ack <= 1'b0;
			end
			else if (cnt != 2'd0)
			begin
				cnt <= cnt - 2'd1;
				if (cnt == 2'd1)
				begin
					ack     <= 1'b1;
					fcsr_we <= wr_fcsr;
				end
			end
			else if (req)
			begin
				cnt <= lat;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!ack && cnt == 2'd1)
			resp <= resp_c;   // held stable while ack is high
	end

	a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ack) |-> $past(req));
	a_op_known: assert property (@(posedge clk) disable iff (!rst_n) req |-> !$isunknown(cmd.op));

endmodule

//--- hw/fpu_unit.sv
`timescale 1ns/100ps

module fpu_unit (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               req,
	input  fpu_pkg::fpu_req_t  cmd,
	output logic               ack,
	output fpu_pkg::fpu_resp_t resp
);
	import fpu_pkg::*;

	word_t       src_a;
	word_t       src_b;
	logic [3:0]  cmp_cond;
	logic [2:0]  cmp_cc;
	logic [7:0]  cmp_fcc;
	word_t       ceil_w;
	word_t       floor_w;
	word_t       trunc_w;
	word_t       round_w;
	logic        invalid_ceil;
	logic        invalid_floor;
	logic        invalid_trunc;
	logic        invalid_round;
	fcsr_t       fcsr;
	word_t       ctl_rdata;
	logic        fcsr_we;
	fcsr_kind_t  fcsr_kind;
	fpu_except_t except;
	logic [7:0]  new_fcc;
	logic [4:0]  ctl_sel;
	word_t       gpr;

	fpu_ex i_fpu_ex (
		.clk, .rst_n, .req, .cmd, .ack, .resp,
		.src_a, .src_b, .cmp_cond, .cmp_cc, .cmp_fcc,
		.ceil_w, .floor_w, .trunc_w, .round_w,
		.invalid_ceil, .invalid_floor, .invalid_trunc, .invalid_round,
		.fcsr, .ctl_rdata, .fcsr_we, .fcsr_kind, .except, .new_fcc, .ctl_sel, .gpr
	);

	fpu_csr i_fpu_csr (
		.clk, .rst_n, .fcsr_we, .fcsr_kind, .except, .new_fcc, .ctl_sel, .gpr,
		.fcsr, .ctl_rdata
	);

	fpu_compare i_fpu_compare (
		.clk, .rst_n, .fs(src_a), .ft(src_b), .cond(cmp_cond), .cc(cmp_cc),
		.fcc_in(fcsr.fcc), .fcc_out(cmp_fcc)
	);

	fpu_float2int i_fpu_float2int (
		.fval(src_a), .ceil_w, .floor_w, .trunc_w, .round_w,
		.invalid_ceil, .invalid_floor, .invalid_trunc, .invalid_round
	);

endmodule

//--- test/tb_fpu_unit.sv
`timescale 1ns/100ps

module tb_fpu_unit;
	import fpu_pkg::*;

	logic      clk;
	logic      rst_n;
	logic      req;
	fpu_req_t  cmd;
	logic      ack;
	fpu_resp_t resp;

	fpu_req_t  cmd_q[$];
	fpu_resp_t exp_q[$];
	int        cycles = 0;
	int        limit = 64;

	fpu_unit i_fpu_unit (
		.clk, .rst_n, .req, .cmd, .ack, .resp
	);

	initial
	begin
		clk = 1'b0;
	end

	always #2 clk = ~clk;

	// cycle budget for the whole run
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= limit)
		begin
			$display("timeout after %0d cycles, ack never arrived", cycles);
			$display("Errors found");
			$fatal(1, "run stopped by timeout");
		end
	end

	task automatic stop_run();
		$display("Errors found");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_except(input string name, input fpu_except_t got,
		input fpu_except_t exp);
		if (got !== exp)
		begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic load_patterns();
		int          fd;
		int          n;
		string       line;
		logic [4:0]  op_v;
		logic [3:0]  cond_v;
		logic [2:0]  cc_v;
		logic [4:0]  sel_v;
		word_t       gpr_v;
		word_t       fs_v;
		word_t       ft_v;
		word_t       fpu_v;
		word_t       cpu_v;
		logic [5:0]  exc_v;
		fpu_req_t    c;
		fpu_resp_t   r;
		fd = $fopen("test/fpu_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open test/fpu_patterns.txt");
			stop_run();
		end
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line[0] == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", op_v, cond_v, cc_v,
				sel_v, gpr_v, fs_v, ft_v, fpu_v, cpu_v, exc_v);
			if (n <= 0)
				continue;   // blank line
			if (n != 10)
			begin
				$display("malformed pattern line: %s", line);
				stop_run();
			end
			c.op      = fpu_op_t'(op_v);
			c.cond    = cond_v;
			c.cc      = cc_v;
			c.ctl_sel = sel_v;
			c.gpr     = gpr_v;
			c.fs      = fs_v;
			c.ft      = ft_v;
			r.fpu_ret = fpu_v;
			r.cpu_ret = cpu_v;
			r.except  = fpu_except_t'(exc_v);
			cmd_q.push_back(c);
			exp_q.push_back(r);
		end
		$fclose(fd);
	endtask

	task automatic check_resp(input int idx, input fpu_resp_t e);
		check_word($sformatf("resp.fpu_ret (pattern %0d)", idx), resp.fpu_ret, e.fpu_ret);
		check_word($sformatf("resp.cpu_ret (pattern %0d)", idx), resp.cpu_ret, e.cpu_ret);
		check_except($sformatf("resp.except (pattern %0d)", idx), resp.except, e.except);
	endtask

	// one four-phase transaction from a falling edge
	task automatic run_one(input int idx, input int hold);
		fpu_resp_t e;
		e = exp_q[idx];
		@(negedge clk);   // one idle cycle with req low
		if (ack)
		begin
			$display("ack rose without req before pattern %0d", idx);
			stop_run();
		end
		cmd = cmd_q[idx];
		req = 1'b1;
		do
			@(negedge clk);
		while (!ack);
		check_resp(idx, e);
		repeat (hold)
		begin
			@(negedge clk);
			if (!ack)
			begin
				$display("ack dropped while req was still high on pattern %0d", idx);
				stop_run();
			end
		end
		if (hold > 0)
			check_resp(idx, e);   // result must stay held
		req = 1'b0;
		do
			@(negedge clk);
		while (ack);
	endtask

	initial
	begin
		rst_n = 1'b0;
		req   = 1'b0;
		cmd   = '0;
		load_patterns();
		if (cmd_q.size() == 0)
		begin
			$display("pattern file holds no transactions");
			stop_run();
		end
		limit = 8 * cmd_q.size() + 64;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		if (ack)
		begin
			$display("ack was high right after reset");
			stop_run();
		end
		for (int i = 0; i < cmd_q.size(); i++)
			run_one(i, (i % 4 == 3) ? 3 : 0);   // back-pressure on every fourth
		$display("No errors");
		$finish;
	end

endmodule

//--- src.f
hw/fpu_pkg.sv
hw/fpu_float2int.sv
hw/fpu_compare.sv
hw/fpu_csr.sv
hw/fpu_ex.sv
hw/fpu_unit.sv
test/tb_fpu_unit.sv

//--- test/fpu_patterns.txt
# op cond cc ctl_sel gpr fs ft | expected fpu_ret cpu_ret except, all hex
# except bits: unimpl invalid divided_by_zero overflow underflow inexact
01 0 0 00 00000000 3fc00000 00000000 3fc00000 00000000 00
02 0 0 00 12345678 00000000 00000000 12345678 00000000 00
03 0 0 00 00000000 c0490fdb 00000000 00000000 c0490fdb 00
04 0 0 00 00000000 3fc00000 00000000 bfc00000 00000000 00
05 0 0 00 00000000 c0200000 00000000 40200000 00000000 00
04 0 0 00 00000000 7fc00001 00000000 7fc00001 00000000 10
05 0 0 00 00000000 ffc00000 00000000 ffc00000 00000000 10
0d 0 0 1a 00000000 00000000 00000000 00000000 00010040 00
06 2 0 00 00000000 00000000 80000000 00000000 00000000 00
06 4 3 00 00000000 bf800000 3f800000 00000000 00000000 00
06 1 5 00 00000000 7fc00000 3f800000 00000000 00000000 00
06 6 0 00 00000000 40000000 3f800000 00000000 00000000 00
06 c 3 00 00000000 7fc00000 00000000 00000000 00000000 00
06 4 2 00 00000000 c0000000 bf800000 00000000 00000000 00
0d 0 0 19 00000000 00000000 00000000 00000000 00000024 00
07 0 0 00 00000000 bfc00000 00000000 ffffffff 00000000 00
08 0 0 00 00000000 bfc00000 00000000 fffffffe 00000000 00
09 0 0 00 00000000 42f78000 00000000 0000007b 00000000 00
0a 0 0 00 00000000 40200000 00000000 00000002 00000000 00
0a 0 0 00 00000000 bfc00000 00000000 fffffffe 00000000 00
09 0 0 00 00000000 4f32d05e 00000000 7fffffff 00000000 10
07 0 0 00 00000000 cf000000 00000000 80000000 00000000 00
0b 0 0 00 00000000 3fc00000 00000000 00000002 00000000 00
0c 0 0 1c 00000f87 00000000 00000000 00000000 00000000 00
0b 0 0 00 00000000 c0200000 00000000 fffffffd 00000000 00
0b 0 0 00 00000000 7fc00000 00000000 7fffffff 00000000 10
0d 0 0 1f 00000000 00000000 00000000 00000000 25010fc3 00
0e 0 0 00 00000000 00000000 00000000 00000000 00000000 20
0d 0 0 1f 00000000 00000000 00000000 00000000 25010fc3 00
0c 0 0 1f 12345678 00000000 00000000 00000000 00000000 00
0d 0 0 1f 00000000 00000000 00000000 00000000 12005678 00
0c 0 0 1a 00000000 00000000 00000000 00000000 00000000 00
09 0 0 00 00000000 4f800000 00000000 7fffffff 00000000 10
0a 0 0 00 00000000 3f000000 00000000 00000000 00000000 00
0d 0 0 1a 00000000 00000000 00000000 00000000 00000040 00
0b 0 0 00 00000000 40200000 00000000 00000002 00000000 00
